//--- common/dsm_pkg.sv
/*
 * Shared package for the delta-sigma modulator
 * Word widths, sample and accumulator types, three-level output codes,
 * feedback levels, quantizer thresholds and clamp limits,
 * fixed loop filter coefficients
 */
package dsm_pkg;

	// Sample word is 11 bits signed with 9 fractional bits
	// Bit 9 weighs 1.0 V and bit 10 is sign plus headroom
	localparam int SAMPLE_W = 11;
	localparam int FRAC_BITS = 9;

	// Full product of two samples
	localparam int ACC_W = 2 * SAMPLE_W;

	// Filter order
	localparam int NUM_STATES = 4;

	// Voltage word, also used for dither and filter output
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Product and accumulator word
	// Back to sample_t by taking bits 19 down to 9
	typedef logic signed [ACC_W-1:0] acc_t;

	// Output level code
	typedef logic [1:0] level_t;

	// Legal level codes, 2'b10 is never driven
	localparam level_t LEVEL_ZERO = 2'b00;
	localparam level_t LEVEL_POS = 2'b01;
	localparam level_t LEVEL_NEG = 2'b11;

	// Feedback voltages for the outer levels
	// +0.5 V
	localparam sample_t VIN_FS_HALF = 11'sh100;
	// -0.5 V
	localparam sample_t VIN_FS_HALF_NEG = 11'sh700;

	// Decision points of the ternary quantizer
	// -0.25 V between -1 and 0
	localparam sample_t THRESH_LOW = 11'sh780;
	// +0.25 V between 0 and +1
	localparam sample_t THRESH_HIGH = 11'sh080;

	// Clamp limits of the quantizer sum, just under +2.0 and -2.0 V
	localparam sample_t SAMPLE_MAX = 11'sh3FF;
	localparam sample_t SAMPLE_MIN = 11'sh400;

	// First row of A, scaled by 2^9 and rounded
	// Rows 1 to 3 are a plain shift of the state vector
	// -0.00195
	localparam sample_t COEF_A0_0 = 11'sh7FF;
	// -1.99805
	localparam sample_t COEF_A0_1 = 11'sh401;
	// -0.00195
	localparam sample_t COEF_A0_2 = 11'sh7FF;
	// -1.0
	localparam sample_t COEF_A0_3 = 11'sh600;

	// Output row C
	// -0.8809
	localparam sample_t COEF_C_0 = 11'sh63D;
	// +0.0664
	localparam sample_t COEF_C_1 = 11'sh022;
	// -0.6094
	localparam sample_t COEF_C_2 = 11'sh6C8;
	// +0.0234
	localparam sample_t COEF_C_3 = 11'sh00C;

	// Direct feedthrough D, about -0.025
	localparam sample_t COEF_D = 11'sh7F3;

endpackage

//--- loop_filter/loop_filter.sv
/*
 * Four-state discrete state-space loop filter
 * Feedback level to voltage mapping and error formation
 * A0 row and C row multiply-accumulate in acc_t, truncation to sample_t
 */
module loop_filter
	import dsm_pkg::*;
(
	input  logic    clock,
	input  logic    reset,

	// Step strobe
	input  logic    sample_i,

	// Modulator input voltage
	input  sample_t vin_i,

	// Registered output level of the previous step
	input  level_t  level_i,

	// Filter output from present state and present error
	output sample_t filt_o
);

	// Level code mapped back to a voltage
	sample_t fb_volt;

	// Error u between input and feedback
	sample_t err_u;

	// State vector x(n)
	sample_t state_q [NUM_STATES];

	// Coefficient rows as arrays for the MAC loops
	sample_t coef_a0 [NUM_STATES];
	sample_t coef_c  [NUM_STATES];

	// Wide sums
	acc_t a0_acc;
	acc_t y_acc;

	// A0 row sum cut back to a sample
	sample_t a0_trunc;

	// Next value of the first state
	sample_t x0_next;

	assign coef_a0[0] = COEF_A0_0;
	assign coef_a0[1] = COEF_A0_1;
	assign coef_a0[2] = COEF_A0_2;
	assign coef_a0[3] = COEF_A0_3;

	assign coef_c[0] = COEF_C_0;
	assign coef_c[1] = COEF_C_1;
	assign coef_c[2] = COEF_C_2;
	assign coef_c[3] = COEF_C_3;

	// Feedback DAC model
	// Code 10 cannot occur and falls to zero
	always_comb begin
		case (level_i)
			LEVEL_POS: fb_volt = VIN_FS_HALF;
			LEVEL_NEG: fb_volt = VIN_FS_HALF_NEG;
			default:   fb_volt = '0;
		endcase
	end

	// Unity forward gain on the input
	assign err_u = vin_i - fb_volt;

	// A0 row product sum
	// Operands sign extended to full product width before the multiply
	always_comb begin
		a0_acc = '0;
		for (int i = 0; i < NUM_STATES; i++) begin
			a0_acc = a0_acc + acc_t'(coef_a0[i]) * acc_t'(state_q[i]);
		end
	end

	// Drop the 9 extra fractional bits and the top guard bits
	assign a0_trunc = a0_acc[FRAC_BITS+SAMPLE_W-1:FRAC_BITS];

	// B is a unit vector, so u enters the first state only
	assign x0_next = a0_trunc + err_u;

	// Output row C times state plus D times u
	always_comb begin
		y_acc = acc_t'(COEF_D) * acc_t'(err_u);
		for (int i = 0; i < NUM_STATES; i++) begin
			y_acc = y_acc + acc_t'(coef_c[i]) * acc_t'(state_q[i]);
		end
	end

	// Same cut as the state path
	assign filt_o = y_acc[FRAC_BITS+SAMPLE_W-1:FRAC_BITS];

	// State register
	// New first state from the A0 row, the rest shift down by one
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_STATES; i++) begin
				state_q[i] <= '0;
			end
		end else if (sample_i) begin
			state_q[0] <= x0_next;
			for (int i = 1; i < NUM_STATES; i++) begin
				state_q[i] <= state_q[i-1];
			end
		end
	end

endmodule

//--- source/ternary_quantizer.sv
/*
 * Ternary quantizer
 * Dithered three-way sum with clamp, threshold decision,
 * registered level code and valid strobe
 */
module ternary_quantizer
	import dsm_pkg::*;
(
	input  logic    clock,
	input  logic    reset,

	// Step strobe
	input  logic    sample_i,

	// Loop filter output
	input  sample_t filt_i,

	// Modulator input, added ahead of the decision
	input  sample_t vin_i,

	// Dither word
	input  sample_t dither_i,

	// Registered decision
	output level_t  level_o,

	// One cycle after each strobe
	output logic    level_valid_o
);

	// Two guard bits cover the sum of three samples
	logic signed [SAMPLE_W+1:0] sum_wide;

	// Sum saturated into the sample range
	sample_t sum_clamped;

	// Combinational level decision
	level_t level_next;

	// Signed operands extend to the sum width
	assign sum_wide = filt_i + vin_i + dither_i;

	// Saturate instead of wrapping so a large sum keeps its sign
	always_comb begin
		if (sum_wide > SAMPLE_MAX) begin
			sum_clamped = SAMPLE_MAX;
		end else if (sum_wide < SAMPLE_MIN) begin
			sum_clamped = SAMPLE_MIN;
		end else begin
			sum_clamped = sum_wide[SAMPLE_W-1:0];
		end
	end

	// Three-level decision at -0.25 and +0.25 V
	always_comb begin
		if (sum_clamped < THRESH_LOW) begin
			level_next = LEVEL_NEG;
		end else if (sum_clamped < THRESH_HIGH) begin
			level_next = LEVEL_ZERO;
		end else begin
			level_next = LEVEL_POS;
		end
	end

	// Level held between strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			level_o <= LEVEL_ZERO;
		end else if (sample_i) begin
			level_o <= level_next;
		end
	end

	// Valid follows every strobe, back to back included
	always_ff @(posedge clock) begin
		if (reset) begin
			level_valid_o <= 1'b0;
		end else begin
			level_valid_o <= sample_i;
		end
	end

endmodule

//--- source/dsm_top.sv
/*
 * Three-level delta-sigma modulator top
 * Loop filter and ternary quantizer with level feedback
 */
module dsm_top
	import dsm_pkg::*;
(
	input  logic    clock,
	input  logic    reset,

	// One modulator step per high cycle
	input  logic    sample_i,

	// Input voltage, read on strobe edges only
	input  sample_t vin_i,

	// External dither added ahead of the decision
	input  sample_t dither_i,

	// Registered level code for the H-bridge PWM
	output level_t  level_o,

	// High in the cycle after each strobe
	output logic    level_valid_o
);

	// Combinational loop filter output
	sample_t filt;

	// Noise shaping filter
	// Error is formed inside from vin and the fed-back level
	loop_filter u_loop_filter (
		.clock    (clock),
		.reset    (reset),
		.sample_i (sample_i),
		.vin_i    (vin_i),
		.level_i  (level_o),
		.filt_o   (filt)
	);

	// Sum of filter output, input and dither
	// Decision registered on the same strobe edge as the filter state
	ternary_quantizer u_ternary_quantizer (
		.clock         (clock),
		.reset         (reset),
		.sample_i      (sample_i),
		.filt_i        (filt),
		.vin_i         (vin_i),
		.dither_i      (dither_i),
		.level_o       (level_o),
		.level_valid_o (level_valid_o)
	);

endmodule

//--- verif/dsm_checker.sv
/*
 * Bound checker for the modulator top
 * Reset values, strobe to valid timing, level hold, legal codes
 */
module dsm_checker
	import dsm_pkg::*;
(
	input logic   clock,
	input logic   reset,

	// Step strobe seen by the DUT
	input logic   sample_i,

	// DUT level output
	input level_t level_i,

	// DUT valid strobe
	input logic   level_valid_i
);

	// Count of failed assertions, polled from the testbench
	int unsigned error_count = 0;

	// Outputs at rest during reset and one cycle after
	reset_state: assert property (@(posedge clock)
		reset |=> (level_i == LEVEL_ZERO && !level_valid_i))
	else begin
		error_count++;
		$error("level_o or level_valid_o not at reset value");
	end

	// Valid exactly one cycle after each strobe
	// Back to back strobes give back to back valids
	strobe_timing: assert property (@(posedge clock) disable iff (reset)
		level_valid_i == $past(sample_i))
	else begin
		error_count++;
		$error("level_valid_o does not follow sample_i by one cycle");
	end

	// No strobe in the last cycle means no change of level
	output_hold: assert property (@(posedge clock) disable iff (reset)
		!$past(sample_i) |-> (level_i == $past(level_i)))
	else begin
		error_count++;
		$error("level_o changed without a strobe");
	end

	// Code 10 must never show, reset or not
	legal_code: assert property (@(posedge clock)
		level_i !== 2'b10)
	else begin
		error_count++;
		$error("level_o took the illegal code 10");
	end

endmodule

//--- verif/dsm_tb.sv
/*
 * Testbench for the three-level delta-sigma modulator
 * Clock, reset, random strobe and dither, three constant input phases
 * Mean feedback and sign checks, checker polling, watchdog
 */
module dsm_tb
	import dsm_pkg::*;
;

	// Run length
	localparam int RESET_CYCLES = 16;
	localparam int NUM_PHASES = 3;
	localparam int STROBES_PER_PHASE = 512;
	// First strobes of a phase let the loop settle
	localparam int SETTLE_STROBES = 128;
	localparam int MEAN_STROBES = STROBES_PER_PHASE - SETTLE_STROBES;
	// Strobe rate is about one in three cycles
	localparam int EXPECTED_CYCLES = RESET_CYCLES + 2
		+ NUM_PHASES * (3 * STROBES_PER_PHASE + 4);
	localparam int WATCHDOG_CYCLES = 3 * EXPECTED_CYCLES;
	// 1/16 V is 32 LSB
	// Scaled to the sum over the mean window
	localparam int MEAN_TOL = 32 * MEAN_STROBES;

	logic    clock;
	logic    reset;
	logic    sample_i;
	sample_t vin_i;
	sample_t dither_i;
	level_t  level_o;
	logic    level_valid_o;

	integer seed = 32'h45be;

	dsm_top uut (
		.clock         (clock),
		.reset         (reset),
		.sample_i      (sample_i),
		.vin_i         (vin_i),
		.dither_i      (dither_i),
		.level_o       (level_o),
		.level_valid_o (level_valid_o)
	);

	// Output assertions live in the bound checker
	bind dsm_top dsm_checker u_checker (
		.clock         (clock),
		.reset         (reset),
		.sample_i      (sample_i),
		.level_i       (level_o),
		.level_valid_i (level_valid_o)
	);

	// Print the reason, then the fail message, then stop
	task automatic stop_with_failure(input string reason);
		$display("%s at time %0t", reason, $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Level code to feedback voltage in LSB of 1/512 V
	function automatic int level_to_lsb(input level_t code);
		if (code == 2'b01) begin
			return 256;
		end else if (code == 2'b11) begin
			return -256;
		end
		return 0;
	endfunction

	// One phase of constant input
	// sign_dir gives the expected sign as 0, +1 or -1
	task automatic run_phase(input sample_t vin, input int sign_dir);
		int strobes_sent;
		int valid_seen;
		int fb_sum;
		int pos_count;
		int neg_count;
		int diff;
		integer r;
		strobes_sent = 0;
		valid_seen = 0;
		fb_sum = 0;
		pos_count = 0;
		neg_count = 0;
		@(posedge clock);
		vin_i <= vin;
		sample_i <= 1'b0;
		while (valid_seen < STROBES_PER_PHASE) begin
			@(posedge clock);
			// Outputs read here still hold the values of the last cycle
			if (level_valid_o) begin
				if (valid_seen >= SETTLE_STROBES) begin
					fb_sum = fb_sum + level_to_lsb(level_o);
					pos_count = pos_count + ((level_o == 2'b01) ? 1 : 0);
					neg_count = neg_count + ((level_o == 2'b11) ? 1 : 0);
				end
				valid_seen = valid_seen + 1;
			end
			// Dither within 8 LSB or 1/64 V
			r = $random(seed);
			dither_i <= sample_t'(r % 9);
			r = $random(seed);
			if (strobes_sent < STROBES_PER_PHASE && (r % 3) == 0) begin
				sample_i <= 1'b1;
				strobes_sent = strobes_sent + 1;
			end else begin
				sample_i <= 1'b0;
			end
		end
		// Level counts lean toward the sign of the input
		if (sign_dir > 0 && !(pos_count > 0 && pos_count > neg_count)) begin
			stop_with_failure("Positive input did not give mostly +1 levels");
		end
		if (sign_dir < 0 && !(neg_count > 0 && neg_count > pos_count)) begin
			stop_with_failure("Negative input did not give mostly -1 levels");
		end
		// Average feedback has to follow the input
		diff = fb_sum - int'(vin) * MEAN_STROBES;
		assert (diff <= MEAN_TOL && diff >= -MEAN_TOL) else begin
			$display("FAIL at time %0t: mean_feedback = %0d LSB, expected %0d LSB",
				$time, fb_sum / MEAN_STROBES, int'(vin));
			stop_with_failure("Mean feedback out of range");
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Any failed checker assertion ends the run
	always @(negedge clock) begin
		if (uut.u_checker.error_count != 0) begin
			stop_with_failure("Checker assertion failed");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		stop_with_failure("Watchdog expired before all phases finished");
	end

	initial begin
		reset = 1'b1;
		sample_i = 1'b0;
		vin_i = '0;
		dither_i = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		// One quiet cycle after reset
		@(posedge clock);
		run_phase(sample_t'(0), 0);
		run_phase(sample_t'(128), 1);
		run_phase(sample_t'(-128), -1);
		@(negedge clock);
		if (uut.u_checker.error_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure("Checker assertion failed at end of run");
		end
	end

endmodule

//--- project.f
common/dsm_pkg.sv
loop_filter/loop_filter.sv
source/ternary_quantizer.sv
source/dsm_top.sv
verif/dsm_checker.sv
verif/dsm_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the modulator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module dsm_tb \
	-Mdir obj_dir \
	-f project.f

# The simulation may stop with an error, the log decides
./obj_dir/Vdsm_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
